/* qspi_bridge.f */
+incdir+src
src/qspi_bridge_pkg.sv
src/qspi_reg_if.sv
src/qspi_msg_rx.sv
src/qspi_cmd_decode.sv
src/qspi_ctrl_regs.sv
src/qspi_resp_tx.sv
src/qspi_bridge.sv
tb/qspi_bridge_props.sv
tb/tb_qspi_bridge.sv

/* Bender.yml */
package:
  name: qspi_bridge

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/qspi_bridge_pkg.sv
      - src/qspi_reg_if.sv
      - src/qspi_msg_rx.sv
      - src/qspi_cmd_decode.sv
      - src/qspi_ctrl_regs.sv
      - src/qspi_resp_tx.sv
      - src/qspi_bridge.sv
  - target: test
    include_dirs:
      - src
    files:
      - tb/qspi_bridge_props.sv
      - tb/tb_qspi_bridge.sv

/* tb/tb_qspi_bridge.sv */
`include "qspi_bridge_config.svh"

module tb_qspi_bridge;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int WAIT_LIMIT = 32;

    logic                     ice_st_spi_clk;
    logic                     spi_cs;
    logic [3:0]               spi_d_in;
    logic [7:0]               spi_d_out;
    logic                     spi_d_oe;
    qspi_bridge_pkg::led_t    ice_led;
    logic [1:0]               sd_init_clk_speed;
    logic [3:0]               sd_init_clk_delay;
    logic                     sd_init_trigger;
    logic                     sd_init_reset;
    logic                     sd_cmd_trigger;
    qspi_bridge_pkg::sd_cmd_t sd_cmd_data;
    logic [1:0]               sd_cmd_resp_type;
    logic [1:0]               sd_cmd_dat_in_type;
    logic                     sd_cmd_done;
    logic                     sd_resp_done;
    logic                     sd_dat_in_done;
    logic                     sd_resp_crc_err;
    logic                     sd_dat_in_crc_err;
    logic                     sd_dat0_idle;
    qspi_bridge_pkg::sd_cmd_t sd_resp_data;

    logic [31:0]              rng_state = 32'd71124;
    int                       value_errs = 0;
    int                       timeout_errs = 0;
    qspi_bridge_pkg::resp_t   got_resp;
    int                       got_bytes;

    // Expected register block contents
    qspi_bridge_pkg::led_t    exp_led = '0;
    logic [1:0]               exp_clk_speed = '0;
    logic [3:0]               exp_clk_delay = '0;
    logic                     exp_init_trigger = 1'b0;
    logic                     exp_init_reset = 1'b0;
    logic                     exp_cmd_trigger = 1'b0;
    qspi_bridge_pkg::sd_cmd_t exp_cmd_data = '0;
    logic [1:0]               exp_resp_type = '0;
    logic [1:0]               exp_dat_in_type = '0;
    // Done acks, {data-in, response, command}
    logic [2:0]               exp_ack = '0;

    qspi_bridge u_qspi_bridge (.*);

    initial begin
        ice_st_spi_clk = 1'b1;
        forever #4 ice_st_spi_clk = ~ice_st_spi_clk;
    end

    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    function automatic qspi_bridge_pkg::msg_arg_t rand_arg();
        logic [31:0] hi;
        hi = next_rand();
        return {hi[23:0], next_rand()};
    endfunction

    function automatic qspi_bridge_pkg::resp_t expected_status();
        qspi_bridge_pkg::msg_arg_t s;
        logic [2:0]                done;
        done = {sd_dat_in_done, sd_resp_done, sd_cmd_done} ^ exp_ack;
        s = '0;
        s[`QSPI_STAT_RESP_BITS]          = sd_resp_data;
        s[`QSPI_STAT_CMD_DONE_BIT]       = done[0];
        s[`QSPI_STAT_RESP_DONE_BIT]      = done[1];
        s[`QSPI_STAT_RESP_CRC_ERR_BIT]   = sd_resp_crc_err;
        s[`QSPI_STAT_DAT_IN_DONE_BIT]    = done[2];
        s[`QSPI_STAT_DAT_IN_CRC_ERR_BIT] = sd_dat_in_crc_err;
        s[`QSPI_STAT_DAT0_IDLE_BIT]      = sd_dat0_idle;
        return {`QSPI_TYPE_SD_STATUS, s};
    endfunction

    task automatic compare_field(input string what, input logic [63:0] got,
                                 input logic [63:0] want);
        assert (got === want) else begin
            $display("FAIL time %0t: %s is %h, expected %h", $time, what, got, want);
            value_errs++;
        end
    endtask

    task automatic check_registers();
        compare_field("ice_led", ice_led, exp_led);
        compare_field("sd_init_clk_speed", sd_init_clk_speed, exp_clk_speed);
        compare_field("sd_init_clk_delay", sd_init_clk_delay, exp_clk_delay);
        compare_field("sd_init_trigger", sd_init_trigger, exp_init_trigger);
        compare_field("sd_init_reset", sd_init_reset, exp_init_reset);
        compare_field("sd_cmd_trigger", sd_cmd_trigger, exp_cmd_trigger);
        compare_field("sd_cmd_data", sd_cmd_data, exp_cmd_data);
        compare_field("sd_cmd_resp_type", sd_cmd_resp_type, exp_resp_type);
        compare_field("sd_cmd_dat_in_type", sd_cmd_dat_in_type, exp_dat_in_type);
    endtask

    // ==================================================================
    // Host side of the quad-SPI port
    // ==================================================================
    task automatic send_message(input qspi_bridge_pkg::msg_type_t mtype,
                                input qspi_bridge_pkg::msg_arg_t arg);
        qspi_bridge_pkg::msg_t m;
        // Host always sends the top type bit as zero
        m = {1'b0, mtype[6:0], arg};
        spi_cs = 1'b1;
        for (int i = 0; i < `QSPI_MSG_CYCLES; i++) begin
            if (i < 2) begin
                spi_d_in = 4'hF;
            end else begin
                spi_d_in = m[`QSPI_MSG_LEN-1 -: 4];
                m = m << 4;
            end
            @(negedge ice_st_spi_clk);
        end
        spi_d_in = '0;
    endtask

    task automatic deselect();
        spi_cs = 1'b0;
        repeat (2) @(negedge ice_st_spi_clk);
    endtask

    task automatic send_silent_command(input qspi_bridge_pkg::msg_type_t mtype,
                                       input qspi_bridge_pkg::msg_arg_t arg);
        logic [2:0] done_now;
        done_now = {sd_dat_in_done, sd_resp_done, sd_cmd_done} ^ exp_ack;
        send_message(mtype, arg);
        // Writes land two edges after the last nibble
        repeat (4) begin
            compare_field("spi_d_oe", spi_d_oe, 1'b0);
            @(negedge ice_st_spi_clk);
        end
        deselect();
        case (mtype)
            `QSPI_TYPE_LED_SET: exp_led = arg[`QSPI_ARG_LED_BITS];
            `QSPI_TYPE_SD_INIT: begin
                exp_clk_speed    = arg[`QSPI_ARG_INIT_CLK_SPEED_BITS];
                exp_clk_delay    = arg[`QSPI_ARG_INIT_CLK_DELAY_BITS];
                exp_init_trigger = exp_init_trigger ^ arg[`QSPI_ARG_INIT_TRIGGER_BIT];
                exp_init_reset   = exp_init_reset ^ arg[`QSPI_ARG_INIT_RESET_BIT];
            end
            `QSPI_TYPE_SD_SEND_CMD: begin
                exp_cmd_data    = arg[`QSPI_ARG_CMD_DATA_BITS];
                exp_resp_type   = arg[`QSPI_ARG_CMD_RESP_TYPE_BITS];
                exp_dat_in_type = arg[`QSPI_ARG_CMD_DAT_IN_TYPE_BITS];
                exp_cmd_trigger = !exp_cmd_trigger;
                exp_ack = exp_ack ^ (done_now & {|exp_dat_in_type, |exp_resp_type, 1'b1});
            end
            default: begin
            end
        endcase
        check_registers();
    endtask

    task automatic send_answered_command(input qspi_bridge_pkg::msg_type_t mtype,
                                         input qspi_bridge_pkg::msg_arg_t arg,
                                         input qspi_bridge_pkg::resp_t want);
        int waited;
        send_message(mtype, arg);
        got_resp = '0;
        got_bytes = 0;
        waited = 0;
        while (!spi_d_oe && waited < WAIT_LIMIT) begin
            @(negedge ice_st_spi_clk);
            waited++;
        end
        if (!spi_d_oe) begin
            $display("Timeout: no response started for type %h", mtype);
            timeout_errs++;
        end
        waited = 0;
        while (spi_d_oe && waited < WAIT_LIMIT) begin
            got_resp = {got_resp[`QSPI_MSG_LEN-9:0], spi_d_out};
            got_bytes++;
            @(negedge ice_st_spi_clk);
            waited++;
        end
        if (spi_d_oe) begin
            $display("Timeout: spi_d_oe never dropped after the response");
            timeout_errs++;
        end
        deselect();
        compare_field("response byte count", got_bytes, `QSPI_RESP_BYTES);
        compare_field("response", got_resp, want);
    endtask

    // SD controller model, toggles done flags and refreshes the status inputs
    task automatic toggle_sd_done(input logic [2:0] which);
        logic [31:0] r;
        r = next_rand();
        sd_cmd_done       = sd_cmd_done ^ which[0];
        sd_resp_done      = sd_resp_done ^ which[1];
        sd_dat_in_done    = sd_dat_in_done ^ which[2];
        sd_resp_crc_err   = r[0];
        sd_dat_in_crc_err = r[1];
        sd_dat0_idle      = r[2];
        sd_resp_data      = {r[31:16], next_rand()};
        // Two synchronizer stages plus margin
        repeat (3) @(negedge ice_st_spi_clk);
    endtask

    // ==================================================================
    // Test sequence
    // ==================================================================
    initial begin
        qspi_bridge_pkg::msg_arg_t arg;
        int                        total;
        spi_cs            = 1'b1;
        spi_d_in          = '0;
        sd_cmd_done       = 1'b0;
        sd_resp_done      = 1'b0;
        sd_dat_in_done    = 1'b0;
        sd_resp_crc_err   = 1'b0;
        sd_dat_in_crc_err = 1'b0;
        sd_dat0_idle      = 1'b0;
        sd_resp_data      = '0;
        @(negedge ice_st_spi_clk);
        deselect();
        compare_field("spi_d_oe after reset", spi_d_oe, 1'b0);
        check_registers();

        repeat (2) begin
            arg = rand_arg();
            send_answered_command(`QSPI_TYPE_ECHO, arg, {`QSPI_TYPE_ECHO, arg});
        end
        repeat (2) send_silent_command(`QSPI_TYPE_LED_SET, rand_arg());
        // Trigger and reset both set, then both clear, then trigger alone
        for (int i = 0; i < 3; i++) begin
            arg = rand_arg();
            arg[`QSPI_ARG_INIT_TRIGGER_BIT] = i != 1;
            arg[`QSPI_ARG_INIT_RESET_BIT]   = i == 0;
            send_silent_command(`QSPI_TYPE_SD_INIT, arg);
        end

        toggle_sd_done(3'b111);
        send_answered_command(`QSPI_TYPE_SD_STATUS, rand_arg(), expected_status());
        // Nonzero response and data-in types clear all three flags
        arg = rand_arg();
        arg[48] = 1'b1;
        arg[51] = 1'b1;
        send_silent_command(`QSPI_TYPE_SD_SEND_CMD, arg);
        send_answered_command(`QSPI_TYPE_SD_STATUS, rand_arg(), expected_status());
        compare_field("done flags after send command", {got_resp[51], got_resp[49:48]}, 3'b000);

        // Zero types clear only command done
        toggle_sd_done(3'b111);
        arg = rand_arg();
        arg[`QSPI_ARG_CMD_DAT_IN_TYPE_BITS] = 2'b00;
        arg[`QSPI_ARG_CMD_RESP_TYPE_BITS]   = 2'b00;
        send_silent_command(`QSPI_TYPE_SD_SEND_CMD, arg);
        send_answered_command(`QSPI_TYPE_SD_STATUS, rand_arg(), expected_status());

        send_silent_command(`QSPI_TYPE_NOP, rand_arg());
        // Unknown type with the response flag set acts as Nop
        send_silent_command(8'hC7, rand_arg());

        total = value_errs + timeout_errs + u_qspi_bridge.u_props.fail_cnt;
        $display("Errors: %0d value, %0d timeout, %0d assertion",
                 value_errs, timeout_errs, u_qspi_bridge.u_props.fail_cnt);
        if (total == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* tb/qspi_bridge_props.sv */
`include "qspi_bridge_config.svh"

module qspi_bridge_props (
    input logic                  ice_st_spi_clk,
    input logic                  spi_cs,
    input logic                  spi_d_oe,
    input logic                  msg_valid,
    input qspi_bridge_pkg::msg_t msg,
    input logic                  resp_load,
    input logic                  psel,
    input logic                  penable,
    input logic                  pready
);
    timeunit 1ns;
    timeprecision 100ps;

    int fail_cnt = 0;

    // ==================================================================
    // Deselect and response output
    // ==================================================================
    a_deselect_idle: assert property (@(posedge ice_st_spi_clk)
        !spi_cs |-> !spi_d_oe && !psel && !penable)
    else begin
        $error("output enable or APB select active while deselected");
        fail_cnt++;
    end

    // Exactly eight response bytes
    a_oe_length: assert property (@(posedge ice_st_spi_clk) disable iff (!spi_cs)
        $rose(spi_d_oe) |-> spi_d_oe [*8] ##1 !spi_d_oe)
    else begin
        $error("spi_d_oe was not high for exactly 8 cycles");
        fail_cnt++;
    end

    a_oe_after_load: assert property (@(posedge ice_st_spi_clk) disable iff (!spi_cs)
        $rose(spi_d_oe) |-> $past(resp_load))
    else begin
        $error("spi_d_oe rose without a response load");
        fail_cnt++;
    end

    // Only Echo and Status answer the host
    a_resp_types: assert property (@(posedge ice_st_spi_clk) disable iff (!spi_cs)
        resp_load |-> {1'b1, msg[62:56]} inside {`QSPI_TYPE_ECHO, `QSPI_TYPE_SD_STATUS})
    else begin
        $error("response loaded for type %h", {1'b1, msg[62:56]});
        fail_cnt++;
    end

    // ==================================================================
    // Message framing and APB phases
    // ==================================================================
    a_msg_pulse: assert property (@(posedge ice_st_spi_clk) disable iff (!spi_cs)
        msg_valid |=> !msg_valid)
    else begin
        $error("msg_valid longer than one cycle");
        fail_cnt++;
    end

    a_apb_setup: assert property (@(posedge ice_st_spi_clk) disable iff (!spi_cs)
        $rose(psel) |-> !penable && $past(msg_valid))
    else begin
        $error("APB setup phase not right after the message");
        fail_cnt++;
    end

    a_apb_access: assert property (@(posedge ice_st_spi_clk) disable iff (!spi_cs)
        psel && !penable |=> psel && penable)
    else begin
        $error("APB access phase missing after setup");
        fail_cnt++;
    end

    a_apb_end: assert property (@(posedge ice_st_spi_clk) disable iff (!spi_cs)
        psel && penable && pready |=> !psel)
    else begin
        $error("APB select held after a completed transfer");
        fail_cnt++;
    end

endmodule

bind qspi_bridge qspi_bridge_props u_props (
    .ice_st_spi_clk (ice_st_spi_clk),
    .spi_cs         (spi_cs),
    .spi_d_oe       (spi_d_oe),
    .msg_valid      (msg_valid),
    .msg            (msg),
    .resp_load      (resp_load),
    .psel           (reg_bus.psel),
    .penable        (reg_bus.penable),
    .pready         (reg_bus.pready)
);

/* src/qspi_bridge.sv */
module qspi_bridge (
    input  logic                     ice_st_spi_clk,
    input  logic                     spi_cs,
    input  logic [3:0]               spi_d_in,
    output logic [7:0]               spi_d_out,
    output logic                     spi_d_oe,
    output qspi_bridge_pkg::led_t    ice_led,
    output logic [1:0]               sd_init_clk_speed,
    output logic [3:0]               sd_init_clk_delay,
    output logic                     sd_init_trigger,
    output logic                     sd_init_reset,
    output logic                     sd_cmd_trigger,
    output qspi_bridge_pkg::sd_cmd_t sd_cmd_data,
    output logic [1:0]               sd_cmd_resp_type,
    output logic [1:0]               sd_cmd_dat_in_type,
    input  logic                     sd_cmd_done,
    input  logic                     sd_resp_done,
    input  logic                     sd_dat_in_done,
    input  logic                     sd_resp_crc_err,
    input  logic                     sd_dat_in_crc_err,
    input  logic                     sd_dat0_idle,
    input  qspi_bridge_pkg::sd_cmd_t sd_resp_data
);

    qspi_bridge_pkg::msg_t  msg;
    logic                   msg_valid;
    qspi_bridge_pkg::resp_t resp;
    logic                   resp_load;

    qspi_reg_if reg_bus ();

    // ==================================================================
    // Command in, decode, response out
    // ==================================================================
    qspi_msg_rx u_msg_rx (
        .ice_st_spi_clk (ice_st_spi_clk),
        .spi_cs         (spi_cs),
        .spi_d_in       (spi_d_in),
        .msg            (msg),
        .msg_valid      (msg_valid)
    );

    qspi_cmd_decode u_cmd_decode (
        .ice_st_spi_clk (ice_st_spi_clk),
        .spi_cs         (spi_cs),
        .msg            (msg),
        .msg_valid      (msg_valid),
        .bus            (reg_bus.master),
        .resp           (resp),
        .resp_load      (resp_load)
    );

    qspi_resp_tx u_resp_tx (
        .ice_st_spi_clk (ice_st_spi_clk),
        .spi_cs         (spi_cs),
        .resp           (resp),
        .resp_load      (resp_load),
        .spi_d_out      (spi_d_out),
        .spi_d_oe       (spi_d_oe)
    );

    // Control registers and SD status
    qspi_ctrl_regs u_ctrl_regs (
        .ice_st_spi_clk     (ice_st_spi_clk),
        .spi_cs             (spi_cs),
        .bus                (reg_bus.slave),
        .ice_led            (ice_led),
        .sd_init_clk_speed  (sd_init_clk_speed),
        .sd_init_clk_delay  (sd_init_clk_delay),
        .sd_init_trigger    (sd_init_trigger),
        .sd_init_reset      (sd_init_reset),
        .sd_cmd_trigger     (sd_cmd_trigger),
        .sd_cmd_data        (sd_cmd_data),
        .sd_cmd_resp_type   (sd_cmd_resp_type),
        .sd_cmd_dat_in_type (sd_cmd_dat_in_type),
        .sd_cmd_done        (sd_cmd_done),
        .sd_resp_done       (sd_resp_done),
        .sd_dat_in_done     (sd_dat_in_done),
        .sd_resp_crc_err    (sd_resp_crc_err),
        .sd_dat_in_crc_err  (sd_dat_in_crc_err),
        .sd_dat0_idle       (sd_dat0_idle),
        .sd_resp_data       (sd_resp_data)
    );

endmodule

/* src/qspi_resp_tx.sv */
`include "qspi_bridge_config.svh"

module qspi_resp_tx (
    input  logic                   ice_st_spi_clk,
    input  logic                   spi_cs,
    input  qspi_bridge_pkg::resp_t resp,
    input  logic                   resp_load,
    output logic [7:0]             spi_d_out,
    output logic                   spi_d_oe
);

    localparam int CNT_W = $clog2(`QSPI_RESP_BYTES + 1);

    logic [CNT_W-1:0]       bytes_left;
    qspi_bridge_pkg::resp_t shift_q;

    always_ff @(posedge ice_st_spi_clk or negedge spi_cs) begin
        if (!spi_cs) begin
            bytes_left <= '0;
        end else if (resp_load) begin
            bytes_left <= CNT_W'(`QSPI_RESP_BYTES);
        end else if (spi_d_oe) begin
            bytes_left <= bytes_left - 1'b1;
        end
    end

    // Most significant byte leaves first
    always_ff @(posedge ice_st_spi_clk) begin
        if (resp_load) begin
            shift_q <= resp;
        end else if (spi_d_oe) begin
            shift_q <= shift_q << 8;
        end
    end

    assign spi_d_out = shift_q[$bits(shift_q)-1 -: 8];
    assign spi_d_oe  = bytes_left != '0;

endmodule

/* src/qspi_ctrl_regs.sv */
`include "qspi_bridge_config.svh"

module qspi_ctrl_regs (
    input  logic                    ice_st_spi_clk,
    input  logic                    spi_cs,
    qspi_reg_if.slave               bus,
    output qspi_bridge_pkg::led_t   ice_led = '0,
    output logic [1:0]              sd_init_clk_speed = '0,
    output logic [3:0]              sd_init_clk_delay = '0,
    output logic                    sd_init_trigger = 1'b0,
    output logic                    sd_init_reset = 1'b0,
    output logic                    sd_cmd_trigger = 1'b0,
    output qspi_bridge_pkg::sd_cmd_t sd_cmd_data = '0,
    output logic [1:0]              sd_cmd_resp_type = '0,
    output logic [1:0]              sd_cmd_dat_in_type = '0,
    input  logic                    sd_cmd_done,
    input  logic                    sd_resp_done,
    input  logic                    sd_dat_in_done,
    input  logic                    sd_resp_crc_err,
    input  logic                    sd_dat_in_crc_err,
    input  logic                    sd_dat0_idle,
    input  qspi_bridge_pkg::sd_cmd_t sd_resp_data
);

    // Bit order is {dat0 idle, data-in done, response done, command done}
    logic [3:0] sync_meta = '0;
    logic [3:0] sync_q = '0;
    // Order {data-in, response, command}
    logic [2:0] done_ack = '0;
    logic [2:0] done_flag;
    logic       wr_en;
    logic       rd_setup;
    qspi_bridge_pkg::msg_arg_t status;

    assign wr_en    = bus.psel && bus.penable && bus.pwrite;
    assign rd_setup = bus.psel && !bus.penable && !bus.pwrite;

    // No wait states
    assign bus.pready = 1'b1;

    // ==================================================================
    // SD side toggles into the SPI clock domain
    // ==================================================================
    always_ff @(posedge ice_st_spi_clk) begin
        sync_meta <= {sd_dat0_idle, sd_dat_in_done, sd_resp_done, sd_cmd_done};
        sync_q    <= sync_meta;
    end

    // Done while the toggle and our ack disagree
    assign done_flag = sync_q[2:0] ^ done_ack;

    always_comb begin
        status = '0;
        status[`QSPI_STAT_RESP_BITS]          = sd_resp_data;
        status[`QSPI_STAT_CMD_DONE_BIT]       = done_flag[0];
        status[`QSPI_STAT_RESP_DONE_BIT]      = done_flag[1];
        status[`QSPI_STAT_RESP_CRC_ERR_BIT]   = sd_resp_crc_err;
        status[`QSPI_STAT_DAT_IN_DONE_BIT]    = done_flag[2];
        status[`QSPI_STAT_DAT_IN_CRC_ERR_BIT] = sd_dat_in_crc_err;
        status[`QSPI_STAT_DAT0_IDLE_BIT]      = sync_q[3];
        status[`QSPI_STAT_ZERO_BITS]          = 2'b00;
    end

    // ==================================================================
    // Register writes
    // ==================================================================
    always_ff @(posedge ice_st_spi_clk) begin
        if (wr_en) begin
            case (bus.paddr)
                `QSPI_REG_ADDR_LED: ice_led <= bus.pwdata[`QSPI_ARG_LED_BITS];
                `QSPI_REG_ADDR_SD_INIT: begin
                    sd_init_clk_delay <= bus.pwdata[`QSPI_ARG_INIT_CLK_DELAY_BITS];
                    sd_init_clk_speed <= bus.pwdata[`QSPI_ARG_INIT_CLK_SPEED_BITS];
                    sd_init_trigger   <= sd_init_trigger ^ bus.pwdata[`QSPI_ARG_INIT_TRIGGER_BIT];
                    sd_init_reset     <= sd_init_reset ^ bus.pwdata[`QSPI_ARG_INIT_RESET_BIT];
                end
                `QSPI_REG_ADDR_SD_CMD: begin
                    sd_cmd_data        <= bus.pwdata[`QSPI_ARG_CMD_DATA_BITS];
                    sd_cmd_resp_type   <= bus.pwdata[`QSPI_ARG_CMD_RESP_TYPE_BITS];
                    sd_cmd_dat_in_type <= bus.pwdata[`QSPI_ARG_CMD_DAT_IN_TYPE_BITS];
                    sd_cmd_trigger     <= !sd_cmd_trigger;
                    // Clear the flags this command will raise again
                    done_ack <= done_ack ^ (done_flag & {
                        |bus.pwdata[`QSPI_ARG_CMD_DAT_IN_TYPE_BITS],
                        |bus.pwdata[`QSPI_ARG_CMD_RESP_TYPE_BITS],
                        1'b1
                    });
                end
                default: begin
                end
            endcase
        end
    end

    // Read data is captured in the setup phase
    always_ff @(posedge ice_st_spi_clk or negedge spi_cs) begin
        if (!spi_cs) begin
            bus.prdata <= '0;
        end else if (rd_setup) begin
            bus.prdata <= (bus.paddr == `QSPI_REG_ADDR_SD_STATUS) ? status : '0;
        end
    end

endmodule

/* src/qspi_cmd_decode.sv */
`include "qspi_bridge_config.svh"

module qspi_cmd_decode (
    input  logic                   ice_st_spi_clk,
    input  logic                   spi_cs,
    input  qspi_bridge_pkg::msg_t  msg,
    input  logic                   msg_valid,
    qspi_reg_if.master             bus,
    output qspi_bridge_pkg::resp_t resp,
    output logic                   resp_load
);

    qspi_bridge_pkg::xact_state_t state;
    qspi_bridge_pkg::msg_type_t   msg_type;
    qspi_bridge_pkg::msg_arg_t    msg_arg;
    qspi_bridge_pkg::reg_addr_t   acc_addr;
    logic                         acc_en;
    logic                         acc_wr;
    logic                         want_resp;

    // The host cannot send a one in the top type bit
    assign msg_type = {1'b1, msg[`QSPI_MSG_LEN-2 -: `QSPI_TYPE_LEN-1]};
    assign msg_arg  = msg[`QSPI_ARG_LEN-1:0];

    // Unknown types behave as Nop, response flag or not
    assign want_resp = msg_type[`QSPI_TYPE_RESP_BIT] &&
                       (msg_type == `QSPI_TYPE_ECHO || msg_type == `QSPI_TYPE_SD_STATUS);

    // ==================================================================
    // Type to register access
    // ==================================================================
    always_comb begin
        acc_en   = 1'b1;
        acc_wr   = 1'b1;
        acc_addr = `QSPI_REG_ADDR_LED;
        case (msg_type)
            `QSPI_TYPE_LED_SET:     acc_addr = `QSPI_REG_ADDR_LED;
            `QSPI_TYPE_SD_INIT:     acc_addr = `QSPI_REG_ADDR_SD_INIT;
            `QSPI_TYPE_SD_SEND_CMD: acc_addr = `QSPI_REG_ADDR_SD_CMD;
            `QSPI_TYPE_SD_STATUS: begin
                acc_wr   = 1'b0;
                acc_addr = `QSPI_REG_ADDR_SD_STATUS;
            end
            // Echo and Nop never touch the registers
            `QSPI_TYPE_ECHO, `QSPI_TYPE_NOP: acc_en = 1'b0;
            default:                         acc_en = 1'b0;
        endcase
    end

    // Setup phase in DECODE, access phase in APB_ACCESS
    assign bus.psel    = acc_en && (state == qspi_bridge_pkg::DECODE ||
                                    state == qspi_bridge_pkg::APB_ACCESS);
    assign bus.penable = state == qspi_bridge_pkg::APB_ACCESS;
    assign bus.pwrite  = acc_wr;
    assign bus.paddr   = acc_addr;
    assign bus.pwdata  = msg_arg;

    assign resp_load = state == qspi_bridge_pkg::RESP_OUT;

    // ==================================================================
    // Transaction FSM
    // ==================================================================
    always_ff @(posedge ice_st_spi_clk or negedge spi_cs) begin
        if (!spi_cs) begin
            state <= qspi_bridge_pkg::MSG_IN;
        end else begin
            case (state)
                qspi_bridge_pkg::MSG_IN: begin
                    if (msg_valid) begin
                        state <= qspi_bridge_pkg::DECODE;
                    end
                end
                qspi_bridge_pkg::DECODE: begin
                    if (acc_en) begin
                        state <= qspi_bridge_pkg::APB_ACCESS;
                    end else if (want_resp) begin
                        state <= qspi_bridge_pkg::RESP_OUT;
                    end else begin
                        state <= qspi_bridge_pkg::DONE;
                    end
                end
                qspi_bridge_pkg::APB_ACCESS: begin
                    if (bus.pready) begin
                        state <= want_resp ? qspi_bridge_pkg::RESP_OUT : qspi_bridge_pkg::DONE;
                    end
                end
                // Stays in DONE until the host deselects
                default: state <= qspi_bridge_pkg::DONE;
            endcase
        end
    end

    // Echo returns its own argument, Status returns the read word
    always_ff @(posedge ice_st_spi_clk) begin
        if (state == qspi_bridge_pkg::DECODE) begin
            resp <= {msg_type, msg_arg};
        end else if (state == qspi_bridge_pkg::APB_ACCESS && !bus.pwrite) begin
            resp <= {msg_type, bus.prdata};
        end
    end

endmodule

/* src/qspi_msg_rx.sv */
`include "qspi_bridge_config.svh"

module qspi_msg_rx (
    input  logic                  ice_st_spi_clk,
    input  logic                  spi_cs,
    input  logic [3:0]            spi_d_in,
    output qspi_bridge_pkg::msg_t msg,
    output logic                  msg_valid
);

    localparam int CNT_W = $clog2(`QSPI_MSG_CYCLES + 1);
    localparam logic [CNT_W-1:0] CNT_END = CNT_W'(`QSPI_MSG_CYCLES);

    logic [CNT_W-1:0] cycle_cnt;
    logic             shifting;

    // Counter saturates after the last nibble so msg holds until deselect
    assign shifting = cycle_cnt != CNT_END;

    always_ff @(posedge ice_st_spi_clk or negedge spi_cs) begin
        if (!spi_cs) begin
            cycle_cnt <= '0;
        end else if (shifting) begin
            cycle_cnt <= cycle_cnt + 1'b1;
        end
    end

    // Commands use the low four data lines only.
    // The two dummy nibbles drop off the top of the register.
    always_ff @(posedge ice_st_spi_clk) begin
        if (shifting) begin
            msg <= {msg[`QSPI_MSG_LEN-5:0], spi_d_in};
        end
    end

    // High during the last input cycle, msg is whole after that edge
    assign msg_valid = cycle_cnt == CNT_END - 1'b1;

endmodule

/* src/qspi_reg_if.sv */
interface qspi_reg_if;

    logic                       psel;
    logic                       penable;
    logic                       pwrite;
    qspi_bridge_pkg::reg_addr_t paddr;
    qspi_bridge_pkg::msg_arg_t  pwdata;
    qspi_bridge_pkg::msg_arg_t  prdata;
    logic                       pready;

    // Command decoder side
    modport master (
        output psel,
        output penable,
        output pwrite,
        output paddr,
        output pwdata,
        input  prdata,
        input  pready
    );

    // Register block side
    modport slave (
        input  psel,
        input  penable,
        input  pwrite,
        input  paddr,
        input  pwdata,
        output prdata,
        output pready
    );

endinterface

/* src/qspi_bridge_pkg.sv */
`include "qspi_bridge_config.svh"

package qspi_bridge_pkg;

    typedef logic [`QSPI_MSG_LEN-1:0]  msg_t;
    typedef logic [`QSPI_TYPE_LEN-1:0] msg_type_t;
    // Argument width doubles as the register bus data width
    typedef logic [`QSPI_ARG_LEN-1:0]  msg_arg_t;
    typedef logic [`QSPI_MSG_LEN-1:0]  resp_t;
    typedef logic [1:0]                reg_addr_t;
    typedef logic [47:0]               sd_cmd_t;
    typedef logic [3:0]                led_t;

    typedef enum logic [2:0] {
        MSG_IN,
        DECODE,
        APB_ACCESS,
        RESP_OUT,
        DONE
    } xact_state_t;

endpackage

/* src/qspi_bridge_config.svh */
`ifndef QSPI_BRIDGE_CONFIG_SVH
`define QSPI_BRIDGE_CONFIG_SVH

// ======================================================================
// Message framing
// ======================================================================
`define QSPI_MSG_LEN        64
// Two dummy nibbles lead every command
`define QSPI_MSG_CYCLES     18
`define QSPI_RESP_BYTES     8
`define QSPI_TYPE_LEN       8
`define QSPI_ARG_LEN        56
`define QSPI_TYPE_RESP_BIT  6

// Message types, top bit is always one after decode
`define QSPI_TYPE_ECHO          8'hC0
`define QSPI_TYPE_LED_SET       8'h81
`define QSPI_TYPE_SD_INIT       8'h82
`define QSPI_TYPE_SD_SEND_CMD   8'h83
`define QSPI_TYPE_SD_STATUS     8'hC4
`define QSPI_TYPE_NOP           8'h80

// Register map
`define QSPI_REG_ADDR_LED       2'd0
`define QSPI_REG_ADDR_SD_INIT   2'd1
`define QSPI_REG_ADDR_SD_CMD    2'd2
`define QSPI_REG_ADDR_SD_STATUS 2'd3

// ======================================================================
// Argument fields
// ======================================================================
`define QSPI_ARG_LED_BITS               3:0
`define QSPI_ARG_INIT_CLK_DELAY_BITS    3:0
`define QSPI_ARG_INIT_CLK_SPEED_BITS    5:4
`define QSPI_ARG_INIT_TRIGGER_BIT       6
`define QSPI_ARG_INIT_RESET_BIT         7
`define QSPI_ARG_CMD_DATA_BITS          47:0
`define QSPI_ARG_CMD_RESP_TYPE_BITS     49:48
`define QSPI_ARG_CMD_DAT_IN_TYPE_BITS   51:50

// Status word
`define QSPI_STAT_RESP_BITS             47:0
`define QSPI_STAT_CMD_DONE_BIT          48
`define QSPI_STAT_RESP_DONE_BIT         49
`define QSPI_STAT_RESP_CRC_ERR_BIT      50
`define QSPI_STAT_DAT_IN_DONE_BIT       51
`define QSPI_STAT_DAT_IN_CRC_ERR_BIT    52
`define QSPI_STAT_DAT0_IDLE_BIT         53
`define QSPI_STAT_ZERO_BITS             55:54

`endif
